//--- fetch_pkg.sv
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int FIP_W       = 28;  // line address, byte address bits 31..4
    localparam int LINE_W      = 128;
    localparam int NUM_BANKS   = 2;   // even and odd
    localparam int TLB_ENTRIES = 8;
    localparam int VPN_W       = 20;
    localparam int PFN_W       = 20;
    localparam int PA_KEEP_W   = 3;   // frame bits kept in the physical line
    localparam int LINE_PA_W   = 11;
    localparam int INDEX_W     = 4;
    localparam int TAG_W       = 6;
    localparam int CACHE_LINES = 16;

    // banks interleave on bit 0, so each bank moves by two lines
    localparam int FIP_STEP    = 2;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [FIP_W-1:0]     fip_t;
    typedef logic [LINE_W-1:0]    line_t;
    typedef logic [VPN_W-1:0]     vpn_t;
    typedef logic [PFN_W-1:0]     pfn_t;
    typedef logic [LINE_PA_W-1:0] line_pa_t;

    typedef enum logic [1:0] {
        CF_NONE,
        CF_BRANCH,
        CF_RESTEER,
        CF_INIT
    } cf_src_e;

    typedef enum logic {
        FILL_IDLE,
        FILL_WAIT  // request out, waiting for the line
    } fill_state_e;

endpackage

//--- fetch_steer.sv
`timescale 1ns/1ps

module fetch_steer import fetch_pkg::*; (
    input  logic                   is_init_i,
    input  logic                   is_resteer_i,
    input  logic                   is_br_t_nt_i,
    input  logic [31:0]            init_addr_i,
    input  fip_t                   bp_fip_e_i,
    input  fip_t                   bp_fip_o_i,
    input  fip_t                   wb_fip_e_i,
    input  fip_t                   wb_fip_o_i,
    output logic                   cf_o,
    output fip_t [NUM_BANKS-1:0]   cf_fip_o
);

    cf_src_e              src;
    fip_t                 init_line;
    fip_t                 init_next;
    fip_t [NUM_BANKS-1:0] bp_fip;
    fip_t [NUM_BANKS-1:0] wb_fip;

    // init beats resteer beats branch
    always_comb begin
        if (is_init_i) begin
            src = CF_INIT;
        end else if (is_resteer_i) begin
            src = CF_RESTEER;
        end else if (is_br_t_nt_i) begin
            src = CF_BRANCH;
        end else begin
            src = CF_NONE;
        end
    end

    assign cf_o = (src != CF_NONE);

    assign init_line = init_addr_i[31 -: FIP_W];  // drop byte offset
    assign init_next = init_line + FIP_W'(1);

    assign bp_fip = {bp_fip_o_i, bp_fip_e_i};
    assign wb_fip = {wb_fip_o_i, wb_fip_e_i};

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        always_comb begin
            case (src)
                // init line goes to the bank of its parity and the next one to the other
                CF_INIT:    cf_fip_o[b] = (init_line[0] == 1'(b)) ? init_line : init_next;
                CF_RESTEER: cf_fip_o[b] = wb_fip[b];
                CF_BRANCH:  cf_fip_o[b] = bp_fip[b];
                default:    cf_fip_o[b] = '0;  // unused without cf_o
            endcase
        end
    end

endmodule

//--- itlb_lookup.sv
`timescale 1ns/1ps

module itlb_lookup import fetch_pkg::*; (
    input  vpn_t                           vpn_i,
    input  logic [TLB_ENTRIES*VPN_W-1:0]   vp_i,
    input  logic [TLB_ENTRIES*PFN_W-1:0]   pf_i,
    input  logic [TLB_ENTRIES-1:0]         entry_v_i,
    input  logic [TLB_ENTRIES-1:0]         entry_p_i,
    output pfn_t                           pfn_o,
    output logic                           hit_o
);

    logic [TLB_ENTRIES-1:0] match;

    // fully associative compare, one per entry
    for (genvar k = 0; k < TLB_ENTRIES; k++) begin : g_entry
        assign match[k] = entry_v_i[k] && entry_p_i[k] &&
                          (vp_i[k*VPN_W +: VPN_W] == vpn_i);
    end

    assign hit_o = |match;

    // walk down so the lowest matching entry is the last one written
    always_comb begin
        pfn_o = '0;
        for (int k = TLB_ENTRIES-1; k >= 0; k--) begin
            if (match[k]) begin
                pfn_o = pf_i[k*PFN_W +: PFN_W];
            end
        end
    end

endmodule

//--- fetch_bank.sv
`timescale 1ns/1ps

module fetch_bank import fetch_pkg::*; #(
    parameter int PARITY = 0  // 0 even bank, 1 odd bank
) (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           cf_i,
    input  fip_t                           cf_fip_i,
    input  logic                           advance_i,
    input  logic [TLB_ENTRIES*VPN_W-1:0]   vp_i,
    input  logic [TLB_ENTRIES*PFN_W-1:0]   pf_i,
    input  logic [TLB_ENTRIES-1:0]         entry_v_i,
    input  logic [TLB_ENTRIES-1:0]         entry_p_i,
    input  logic                           fill_we_i,
    input  line_t                          fill_data_i,
    output logic [1:0]                     fip_lsb_o,
    output logic                           tlb_miss_o,
    output line_t                          line_o,
    output logic                           line_miss_o,
    output line_pa_t                       miss_pa_o
);

    fip_t                   fip_q;
    fip_t                   fip;
    pfn_t                   pfn;
    logic                   tlb_hit;
    line_pa_t               pa;
    logic [INDEX_W-1:0]     index;
    logic [TAG_W-1:0]       tag;
    logic [CACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    line_t                  data_q [CACHE_LINES];

    ////////////////////////////////////////////////////////////////////////////
    // fetch address
    ////////////////////////////////////////////////////////////////////////////

    assign fip = cf_i ? cf_fip_i : fip_q;  // redirect shows up this cycle

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            fip_q <= FIP_W'(PARITY);
        end else if (cf_i) begin
            fip_q <= cf_fip_i;
        end else if (advance_i) begin
            fip_q <= fip + FIP_W'(FIP_STEP);
        end
    end

    assign fip_lsb_o = fip[1:0];

    ////////////////////////////////////////////////////////////////////////////
    // translation
    ////////////////////////////////////////////////////////////////////////////

    itlb_lookup u_itlb (
        .vpn_i     (fip[FIP_W-1 -: VPN_W]),  // 4k pages
        .vp_i      (vp_i),
        .pf_i      (pf_i),
        .entry_v_i (entry_v_i),
        .entry_p_i (entry_p_i),
        .pfn_o     (pfn),
        .hit_o     (tlb_hit)
    );

    assign tlb_miss_o = !tlb_hit;

    assign pa    = {pfn[PA_KEEP_W-1:0], fip[LINE_PA_W-PA_KEEP_W-1:0]};
    assign index = pa[INDEX_W:1];  // bit 0 picks the bank
    assign tag   = pa[LINE_PA_W-1 -: TAG_W];

    ////////////////////////////////////////////////////////////////////////////
    // line storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_we_i) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we_i) begin
            tag_q[index]  <= tag;
            data_q[index] <= fill_data_i;
        end
    end

    assign line_o = data_q[index];

    // no fill without a translation
    assign line_miss_o = tlb_hit && (!valid_q[index] || (tag_q[index] != tag));
    assign miss_pa_o   = pa;

endmodule

//--- line_fill_ctrl.sv
`timescale 1ns/1ps

module line_fill_ctrl import fetch_pkg::*; (
    input  logic                         clk,
    input  logic                         rst_n_i,
    input  logic [NUM_BANKS-1:0]         line_miss_i,
    input  line_pa_t [NUM_BANKS-1:0]     miss_pa_i,
    input  logic                         fill_valid_i,
    output logic                         fill_req_o,
    output line_pa_t                     fill_pa_o,
    output logic [NUM_BANKS-1:0]         fill_we_o,
    output logic [NUM_BANKS-1:0]         cache_miss_o,
    output logic [NUM_BANKS-1:0]         fill_busy_o
);

    fill_state_e          state_q;
    logic [NUM_BANKS-1:0] pick;
    line_pa_t             pick_pa;
    logic [NUM_BANKS-1:0] grant_q;  // one-hot owner of the fill
    line_pa_t             pa_q;

    // lowest bank wins, so even goes first
    always_comb begin
        pick    = '0;
        pick_pa = miss_pa_i[0];
        for (int b = NUM_BANKS-1; b >= 0; b--) begin
            if (line_miss_i[b]) begin
                pick    = NUM_BANKS'(1) << b;
                pick_pa = miss_pa_i[b];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= FILL_IDLE;
        end else begin
            case (state_q)
                FILL_IDLE: if (|line_miss_i) state_q <= FILL_WAIT;
                FILL_WAIT: if (fill_valid_i) state_q <= FILL_IDLE;  // line written
                default:   state_q <= FILL_IDLE;
            endcase
        end
    end

    // capture owner and address on the way out of idle
    always_ff @(posedge clk) begin
        if (state_q == FILL_IDLE && |line_miss_i) begin
            grant_q <= pick;
            pa_q    <= pick_pa;
        end
    end

    assign fill_req_o = (state_q == FILL_WAIT);
    assign fill_pa_o  = pa_q;

    // stray fill_valid in idle falls through here
    assign fill_we_o    = (fill_req_o && fill_valid_i) ? grant_q : '0;
    assign cache_miss_o = line_miss_i | fill_we_o;
    assign fill_busy_o  = fill_we_o;

endmodule

//--- fetch_1.sv
`timescale 1ns/1ps

module fetch_1 import fetch_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           is_init_i,
    input  logic                           is_resteer_i,
    input  logic                           is_br_t_nt_i,
    input  logic [31:0]                    init_addr_i,
    input  fip_t                           bp_fip_e_i,
    input  fip_t                           bp_fip_o_i,
    input  fip_t                           wb_fip_e_i,
    input  fip_t                           wb_fip_o_i,
    input  logic                           even_latch_was_loaded_i,
    input  logic                           odd_latch_was_loaded_i,
    input  logic [TLB_ENTRIES*VPN_W-1:0]   vp_i,
    input  logic [TLB_ENTRIES*PFN_W-1:0]   pf_i,
    input  logic [TLB_ENTRIES-1:0]         tlb_entry_v_i,
    input  logic [TLB_ENTRIES-1:0]         tlb_entry_p_i,
    input  logic                           fill_valid_i,
    input  line_t                          fill_data_i,
    output logic                           tlb_miss_e_o,
    output logic                           tlb_miss_o_o,
    output line_t                          line_even_o,
    output line_t                          line_odd_o,
    output logic                           cache_miss_even_o,
    output logic                           cache_miss_odd_o,
    output logic                           even_w_o,
    output logic                           odd_w_o,
    output logic [1:0]                     fip_e_lsb_o,
    output logic [1:0]                     fip_o_lsb_o,
    output logic                           fill_req_o,
    output line_pa_t                       fill_pa_o
);

    logic                          cf;
    fip_t [NUM_BANKS-1:0]          cf_fip;
    logic [NUM_BANKS-1:0]          advance;
    logic [NUM_BANKS-1:0][1:0]     fip_lsb;
    logic [NUM_BANKS-1:0]          tlb_miss;
    line_t [NUM_BANKS-1:0]         line;
    logic [NUM_BANKS-1:0]          line_miss;
    line_pa_t [NUM_BANKS-1:0]      miss_pa;
    logic [NUM_BANKS-1:0]          fill_we;
    logic [NUM_BANKS-1:0]          cache_miss;
    logic [NUM_BANKS-1:0]          fill_busy;

    fetch_steer u_steer (
        .is_init_i    (is_init_i),
        .is_resteer_i (is_resteer_i),
        .is_br_t_nt_i (is_br_t_nt_i),
        .init_addr_i  (init_addr_i),
        .bp_fip_e_i   (bp_fip_e_i),
        .bp_fip_o_i   (bp_fip_o_i),
        .wb_fip_e_i   (wb_fip_e_i),
        .wb_fip_o_i   (wb_fip_o_i),
        .cf_o         (cf),
        .cf_fip_o     (cf_fip)
    );

    assign advance = {odd_latch_was_loaded_i, even_latch_was_loaded_i};

    // index 0 even, index 1 odd
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        fetch_bank #(.PARITY(b)) u_bank (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .cf_i        (cf),
            .cf_fip_i    (cf_fip[b]),
            .advance_i   (advance[b]),
            .vp_i        (vp_i),
            .pf_i        (pf_i),
            .entry_v_i   (tlb_entry_v_i),
            .entry_p_i   (tlb_entry_p_i),
            .fill_we_i   (fill_we[b]),
            .fill_data_i (fill_data_i),
            .fip_lsb_o   (fip_lsb[b]),
            .tlb_miss_o  (tlb_miss[b]),
            .line_o      (line[b]),
            .line_miss_o (line_miss[b]),
            .miss_pa_o   (miss_pa[b])
        );
    end

    line_fill_ctrl u_fill (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .line_miss_i  (line_miss),
        .miss_pa_i    (miss_pa),
        .fill_valid_i (fill_valid_i),
        .fill_req_o   (fill_req_o),
        .fill_pa_o    (fill_pa_o),
        .fill_we_o    (fill_we),
        .cache_miss_o (cache_miss),
        .fill_busy_o  (fill_busy)
    );

    assign tlb_miss_e_o      = tlb_miss[0];
    assign tlb_miss_o_o      = tlb_miss[1];
    assign line_even_o       = line[0];
    assign line_odd_o        = line[1];
    assign cache_miss_even_o = cache_miss[0];
    assign cache_miss_odd_o  = cache_miss[1];
    assign even_w_o          = fill_busy[0];  // bank is being written, line not usable
    assign odd_w_o           = fill_busy[1];
    assign fip_e_lsb_o       = fip_lsb[0];
    assign fip_o_lsb_o       = fip_lsb[1];

endmodule

//--- fetch_sva.sv
`timescale 1ns/1ps

module line_fill_sva import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 fill_req_i,
    input  line_pa_t             fill_pa_i,
    input  logic [NUM_BANKS-1:0] fill_we_i
);

    // one bank written per fill at most
    a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(fill_we_i))
        else $error("fill write enable is not one-hot");

    a_pa_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
        (fill_req_i && $past(fill_req_i)) |-> $stable(fill_pa_i))  // address held
        else $error("fill address changed while the request was up");

    a_we_needs_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|fill_we_i) |-> fill_req_i)
        else $error("fill write without a pending request");

endmodule

bind line_fill_ctrl line_fill_sva u_sva (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .fill_req_i (fill_req_o),
    .fill_pa_i  (fill_pa_o),
    .fill_we_i  (fill_we_o)
);

//--- tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch import fetch_pkg::*; ();

    localparam int REQ_TIMEOUT = 50;  // cycles
    localparam int QUIET_CYCLES = 30;

    logic                         clk;
    logic                         rst_n_i;
    logic                         is_init_i;
    logic                         is_resteer_i;
    logic                         is_br_t_nt_i;
    logic [31:0]                  init_addr_i;
    fip_t                         bp_fip_e_i;
    fip_t                         bp_fip_o_i;
    fip_t                         wb_fip_e_i;
    fip_t                         wb_fip_o_i;
    logic                         even_latch_was_loaded_i;
    logic                         odd_latch_was_loaded_i;
    logic [TLB_ENTRIES*VPN_W-1:0] vp_i;
    logic [TLB_ENTRIES*PFN_W-1:0] pf_i;
    logic [TLB_ENTRIES-1:0]       tlb_entry_v_i;
    logic [TLB_ENTRIES-1:0]       tlb_entry_p_i;
    logic                         fill_valid_i;
    line_t                        fill_data_i;
    logic                         tlb_miss_e_o;
    logic                         tlb_miss_o_o;
    logic                         cache_miss_even_o;
    logic                         cache_miss_odd_o;
    logic                         even_w_o;
    logic                         odd_w_o;
    logic                         fill_req_o;
    line_t                        line_even_o;
    line_t                        line_odd_o;
    logic [1:0]                   fip_e_lsb_o;
    logic [1:0]                   fip_o_lsb_o;
    line_pa_t                     fill_pa_o;

    integer seed = 14792;
    logic reported = 1'b0;
    line_t cache_model [NUM_BANKS][CACHE_LINES];  // written lines per bank and index

    fetch_1 uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic check(input string name, input logic [127:0] exp_v,
                         input logic [127:0] act_v);
        if (exp_v !== act_v) begin
            reported = 1'b1;
            $display("MISMATCH %s expected %0h actual %0h", name, exp_v, act_v);
            $display("TEST FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    // identity map so the frame is the page of the line
    function automatic line_pa_t expect_pa(input fip_t fip);
        pfn_t frame;
        frame = fip[FIP_W-1 -: VPN_W];
        expect_pa = {frame[PA_KEEP_W-1:0], fip[7:0]};
    endfunction

    task automatic wait_for_req(input string name);
        int n;
        n = 0;
        while (fill_req_o !== 1'b1 && n < REQ_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (fill_req_o !== 1'b1) begin
            reported = 1'b1;
            $display("%s: no fill request within %0d cycles", name, REQ_TIMEOUT);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    endtask

    task automatic serve_fill(input string name, input int bank, input fip_t fip);
        line_pa_t pa;
        line_t data;
        pa = expect_pa(fip);
        wait_for_req(name);
        check({name, " fill_pa"}, 128'(pa), 128'(fill_pa_o));
        data = {$random(seed), $random(seed), $random(seed), $random(seed)};
        fill_valid_i = 1'b1;
        fill_data_i  = data;
        #1;
        check({name, " even_w"}, 128'(bank == 0), 128'(even_w_o));
        check({name, " odd_w"}, 128'(bank == 1), 128'(odd_w_o));
        cache_model[bank][pa[4:1]] = data;
        @(negedge clk);
        fill_valid_i = 1'b0;
        check({name, " req drop"}, 128'(0), 128'(fill_req_o));  // idle for one cycle
    endtask

    task automatic expect_no_req(input string name);
        for (int n = 0; n < QUIET_CYCLES; n++) begin
            @(negedge clk);
            check({name, " no request"}, 128'(0), 128'(fill_req_o));
        end
    endtask

    task automatic steer_branch(input fip_t fe, input fip_t fo);
        is_br_t_nt_i = 1'b1;
        bp_fip_e_i   = fe;
        bp_fip_o_i   = fo;
        @(negedge clk);
        is_br_t_nt_i = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_state();
        check("reset fip_e", 128'(0), 128'(fip_e_lsb_o));
        check("reset fip_o", 128'(1), 128'(fip_o_lsb_o));
        check("reset req", 128'(0), 128'(fill_req_o));
        check("reset tlb_e", 128'(1), 128'(tlb_miss_e_o));  // all entries invalid
        check("reset tlb_o", 128'(1), 128'(tlb_miss_o_o));
        expect_no_req("reset");
    endtask

    task automatic init_split();
        tlb_entry_v_i = '1;
        tlb_entry_p_i = '1;
        is_init_i     = 1'b1;
        init_addr_i   = 32'h0000_0120;  // line 0x12 is even
        @(negedge clk);
        is_init_i = 1'b0;
        serve_fill("init0 even", 0, 28'h12);
        serve_fill("init0 odd", 1, 28'h13);
        is_init_i   = 1'b1;
        init_addr_i = 32'h0000_0350;  // line 0x35 is odd
        @(negedge clk);
        is_init_i = 1'b0;
        serve_fill("init1 even", 0, 28'h36);
        serve_fill("init1 odd", 1, 28'h35);
    endtask

    task automatic steer_priority();
        is_init_i    = 1'b1;
        is_resteer_i = 1'b1;
        is_br_t_nt_i = 1'b1;
        init_addr_i  = 32'h0000_2400;
        wb_fip_e_i   = 28'h4A0;
        wb_fip_o_i   = 28'h4A1;
        bp_fip_e_i   = 28'h6C0;
        bp_fip_o_i   = 28'h6C1;
        @(negedge clk);
        is_init_i    = 1'b0;
        is_resteer_i = 1'b0;
        is_br_t_nt_i = 1'b0;
        serve_fill("prio init even", 0, 28'h240);
        serve_fill("prio init odd", 1, 28'h241);
        is_resteer_i = 1'b1;
        is_br_t_nt_i = 1'b1;
        wb_fip_e_i   = 28'h4A2;
        wb_fip_o_i   = 28'h4A3;
        bp_fip_e_i   = 28'h6C2;
        bp_fip_o_i   = 28'h6C3;
        @(negedge clk);
        is_resteer_i = 1'b0;
        is_br_t_nt_i = 1'b0;
        serve_fill("prio wb even", 0, 28'h4A2);
        serve_fill("prio wb odd", 1, 28'h4A3);
    endtask

    task automatic hit_after_fill();
        even_latch_was_loaded_i = 1'b1;  // takes effect at the next edge
        #1;
        check("hit line even", cache_model[0][1], line_even_o);  // fip 0x4A2
        check("hit line odd", cache_model[1][1], line_odd_o);
        check("hit miss even", 128'(0), 128'(cache_miss_even_o));
        check("hit miss odd", 128'(0), 128'(cache_miss_odd_o));
        @(negedge clk);
        even_latch_was_loaded_i = 1'b0;
        serve_fill("advance even", 0, 28'h4A4);
        steer_branch(28'h4A2, 28'h4A3);
        #1;
        check("back line even", cache_model[0][1], line_even_o);
        check("back line odd", cache_model[1][1], line_odd_o);
        check("back miss even", 128'(0), 128'(cache_miss_even_o));
        check("back req", 128'(0), 128'(fill_req_o));
        @(negedge clk);
    endtask

    task automatic bank_arbitration();
        steer_branch(28'h5C0, 28'h5C1);
        serve_fill("arb even", 0, 28'h5C0);
        serve_fill("arb odd", 1, 28'h5C1);
    endtask

    task automatic tlb_miss_block();
        tlb_entry_v_i[3] = 1'b0;
        is_br_t_nt_i     = 1'b1;
        bp_fip_e_i       = 28'h300;  // page 3
        bp_fip_o_i       = 28'h301;
        #1;
        check("tlb miss even", 128'(1), 128'(tlb_miss_e_o));
        check("tlb miss odd", 128'(1), 128'(tlb_miss_o_o));
        @(negedge clk);
        is_br_t_nt_i = 1'b0;
        fill_valid_i = 1'b1;  // stray pulse with nothing pending
        #1;
        check("stray even_w", 128'(0), 128'(even_w_o));
        check("stray odd_w", 128'(0), 128'(odd_w_o));
        @(negedge clk);
        fill_valid_i = 1'b0;
        expect_no_req("tlb miss");
    endtask

    initial begin
        rst_n_i                 = 1'b0;
        is_init_i               = 1'b0;
        is_resteer_i            = 1'b0;
        is_br_t_nt_i            = 1'b0;
        init_addr_i             = '0;
        bp_fip_e_i              = '0;
        bp_fip_o_i              = '0;
        wb_fip_e_i              = '0;
        wb_fip_o_i              = '0;
        even_latch_was_loaded_i = 1'b0;
        odd_latch_was_loaded_i  = 1'b0;
        for (int k = 0; k < TLB_ENTRIES; k++) begin
            vp_i[k*VPN_W +: VPN_W] = VPN_W'(k);
            pf_i[k*PFN_W +: PFN_W] = PFN_W'(k);
        end
        tlb_entry_v_i = '0;
        tlb_entry_p_i = '0;
        fill_valid_i  = 1'b0;
        fill_data_i   = '0;
        repeat (16) @(negedge clk);
        rst_n_i = 1'b1;
        reset_state();
        init_split();
        steer_priority();
        hit_after_fill();
        bank_arbitration();
        tlb_miss_block();
        reported = 1'b1;
        $display("TEST PASS");
        $finish;
    end

    final begin
        if (!reported) begin
            $display("TEST FAIL");
        end
    end

endmodule

//--- compile.f
fetch_pkg.sv
fetch_steer.sv
itlb_lookup.sv
fetch_bank.sv
line_fill_ctrl.sv
fetch_1.sv
fetch_sva.sv
tb_fetch.sv

//--- run.sh
#!/bin/sh
# build and run the fetch testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_fetch -f compile.f -o tb_fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
    exit 0
fi
echo "pass line not found in sim.log"
exit 1
